// ==== rtl/acq_pkg.sv ====
//**********************************************************
// acquisition constants
// channel count, sample format and ADC period phases
//**********************************************************

package acq_pkg;

    //**********************************************************
    // ADC front end
    //**********************************************************
    localparam int adc_channels = 8;          // channels taken per sample
    localparam int sample_width = 18;         // bits per channel conversion

    typedef logic [sample_width-1:0] sample_t;

    //**********************************************************
    // sample period
    //**********************************************************
    localparam int phase_len = 40;            // adc_data_clk cycles per ADC period

    typedef logic [5:0] phase_t;              // holds 0..phase_len-1

    localparam phase_t phase_last = phase_t'(phase_len - 1);

    // phase values seen on the phase bus at the clock edge that acts
    localparam phase_t capture_phase = phase_t'(1);   // channels + endian latched
    localparam phase_t admit_phase   = phase_t'(2);   // room sampled, word 0 loaded

    // phases during which the two words sit on the write port
    localparam phase_t write0_phase = phase_t'(3);
    localparam phase_t write1_phase = phase_t'(4);   // counters advance here too

endpackage

// ==== rtl/stream_pkg.sv ====
//**********************************************************
// stream constants and types
// output word format, packet length and FIFO sizing
//**********************************************************

package stream_pkg;

    localparam int word_width       = 128;
    localparam int lanes_per_word   = 4;
    localparam int lane_width       = word_width / lanes_per_word;   // 32 bit lanes
    localparam int words_per_sample = 2;      // 8 channels over two words
    localparam int count_width      = 64;     // running sample count
    localparam int pkt_samples      = 16;     // admitted samples per packet
    localparam int pkt_cnt_width    = $clog2(pkt_samples);

    typedef logic [word_width-1:0]    word_t;
    typedef logic [count_width-1:0]   count_t;
    typedef logic [pkt_cnt_width-1:0] pkt_cnt_t;

    localparam pkt_cnt_t pkt_last = pkt_cnt_t'(pkt_samples - 1);   // tlast slot

    // FIFO sizing
    localparam int fifo_depth     = 32;       // in words
    localparam int fifo_ptr_width = $clog2(fifo_depth);
    localparam int fifo_cnt_width = $clog2(fifo_depth + 1);

    typedef logic [fifo_ptr_width-1:0] fifo_ptr_t;
    typedef logic [fifo_cnt_width-1:0] fifo_cnt_t;

    localparam fifo_cnt_t fifo_full  = fifo_cnt_t'(fifo_depth);
    localparam fifo_cnt_t room_limit = fifo_cnt_t'(fifo_depth - words_per_sample);

endpackage

// ==== rtl/sample_phase_counter.sv ====
//**********************************************************
// sample phase counter
// free running cycle count inside each ADC sample period
//**********************************************************

`timescale 1ns/1ps

module sample_phase_counter (
    input  logic            adc_data_clk,
    input  logic            acq_on,          // low holds phase at 0
    output acq_pkg::phase_t phase
);

    //**********************************************************
    // period counter
    //**********************************************************
    // phase is 0 in the first cycle after acq_on rises,
    // then runs 0..phase_len-1 and wraps
    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on) begin
            phase <= '0;
        end else if (phase == acq_pkg::phase_last) begin
            phase <= '0;                          // start of next ADC period
        end else begin
            phase <= phase + 1'b1;
        end
    end

    //**********************************************************
    // checks
    //**********************************************************
    // 6 bit counter could hold 63, the packer decodes only 0..39
    phase_in_range: assert property (
        @(posedge adc_data_clk) disable iff (!acq_on)
        phase <= acq_pkg::phase_last
    );

endmodule

// ==== rtl/sample_packer.sv ====
//**********************************************************
// sample packer
// captures the eight channels, builds two tagged 128 bit
// words with the sample count, optional byte swap, admits
// whole samples only when the FIFO has room for both words
//**********************************************************

`timescale 1ns/1ps

module sample_packer (
    input  logic                                         adc_data_clk,
    input  logic                                         acq_on,
    input  acq_pkg::phase_t                              phase,
    input  acq_pkg::sample_t [acq_pkg::adc_channels-1:0] adc_data,
    input  logic                                         big_endian,  // host byte order
    input  logic                                         room,        // FIFO can take 2 words
    output logic                                         wr_valid,
    output stream_pkg::word_t                            wr_data,
    output logic                                         wr_last
);

    acq_pkg::sample_t [acq_pkg::adc_channels-1:0] chan_q;   // channels of this period
    logic                 endian_q;                      // byte order of this period
    stream_pkg::count_t   sample_cnt;                    // every period, dropped or not
    stream_pkg::pkt_cnt_t pkt_cnt;                       // admitted samples in packet
    logic                 admit;                         // this sample goes to the FIFO

    stream_pkg::word_t word_raw [stream_pkg::words_per_sample];
    stream_pkg::word_t word_out [stream_pkg::words_per_sample];

    // full 16 byte reversal for a big endian host
    function automatic stream_pkg::word_t byte_swap(input stream_pkg::word_t d);
        stream_pkg::word_t s;
        for (int b = 0; b < stream_pkg::word_width / 8; b++) begin
            s[8*b +: 8] = d[stream_pkg::word_width - 8 - 8*b +: 8];
        end
        return s;
    endfunction

    //**********************************************************
    // word builder
    //**********************************************************
    // lane j of word w = {channel, 2'b00, channel index, count byte}
    // both indices are 4w+j, lane 0 is the low lane
    always_comb begin
        for (int w = 0; w < stream_pkg::words_per_sample; w++) begin
            for (int j = 0; j < stream_pkg::lanes_per_word; j++) begin
                word_raw[w][j*stream_pkg::lane_width +: stream_pkg::lane_width] = {
                    chan_q[w*stream_pkg::lanes_per_word + j],
                    2'b00,                                        // spare bits
                    4'(w*stream_pkg::lanes_per_word + j),         // channel tag
                    sample_cnt[8*(w*stream_pkg::lanes_per_word + j) +: 8]
                };
            end
            word_out[w] = endian_q ? byte_swap(word_raw[w]) : word_raw[w];
        end
    end

    //**********************************************************
    // capture and write data path
    //**********************************************************
    always_ff @(posedge adc_data_clk) begin
        if (phase == acq_pkg::capture_phase) begin
            chan_q   <= adc_data;         // all channels in one shot
            endian_q <= big_endian;       // held for the whole sample
        end
        if (phase == acq_pkg::admit_phase) begin
            wr_data <= word_out[0];       // on the port during write0_phase
        end else if (phase == acq_pkg::write0_phase) begin
            wr_data <= word_out[1];       // on the port during write1_phase
        end
    end

    //**********************************************************
    // admission, write strobes and counters
    //**********************************************************
    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on) begin
            sample_cnt <= '0;
            pkt_cnt    <= '0;
            admit      <= 1'b0;
            wr_valid   <= 1'b0;
            wr_last    <= 1'b0;
        end else begin
            wr_valid <= 1'b0;             // one cycle strobes by default
            wr_last  <= 1'b0;
            case (phase)
                acq_pkg::admit_phase: begin
                    admit    <= room;     // whole sample or nothing
                    wr_valid <= room;     // word 0
                end
                acq_pkg::write0_phase: begin
                    wr_valid <= admit;    // word 1
                    wr_last  <= admit && (pkt_cnt == stream_pkg::pkt_last);
                end
                acq_pkg::write1_phase: begin
                    sample_cnt <= sample_cnt + 1'b1;   // drops leave gaps in the count
                    if (admit) begin
                        pkt_cnt <= pkt_cnt + 1'b1;     // wraps at pkt_samples
                    end
                end
                default: begin
                end
            endcase
        end
    end

    //**********************************************************
    // checks
    //**********************************************************
    // writes only appear in the two slots after admission
    wr_in_write_slots: assert property (
        @(posedge adc_data_clk) disable iff (!acq_on)
        wr_valid |-> (phase == acq_pkg::write0_phase || phase == acq_pkg::write1_phase)
    );

    // last is a tag on word 1, never a write on its own
    last_with_valid: assert property (
        @(posedge adc_data_clk) disable iff (!acq_on)
        wr_last |-> wr_valid
    );

endmodule

// ==== rtl/stream_fifo.sv ====
//**********************************************************
// stream FIFO
// single clock word FIFO with show ahead valid/ready output
// and a flag telling the packer a whole sample still fits
//**********************************************************

`timescale 1ns/1ps

module stream_fifo (
    input  logic              adc_data_clk,
    input  logic              acq_on,
    input  logic              wr_valid,       // no write ready, packer checks room
    input  stream_pkg::word_t wr_data,
    input  logic              wr_last,
    input  logic              m_tready,
    output logic              room,
    output logic              m_tvalid,
    output stream_pkg::word_t m_tdata,
    output logic              m_tlast
);

    stream_pkg::word_t    mem      [stream_pkg::fifo_depth];
    logic                 last_mem [stream_pkg::fifo_depth];
    stream_pkg::fifo_ptr_t wr_ptr;
    stream_pkg::fifo_ptr_t rd_ptr;
    stream_pkg::fifo_cnt_t used;               // words stored, 0..fifo_depth
    logic                 rd_en;
    logic                 full;

    assign rd_en    = m_tvalid && m_tready;    // word leaves this cycle
    assign full     = (used == stream_pkg::fifo_full);
    assign room     = (used <= stream_pkg::room_limit);   // free >= words_per_sample
    assign m_tvalid = (used != '0);            // one cycle after the first write
    assign m_tdata  = mem[rd_ptr];             // show ahead head word
    assign m_tlast  = last_mem[rd_ptr];

    //**********************************************************
    // storage
    //**********************************************************
    always_ff @(posedge adc_data_clk) begin
        if (wr_valid) begin
            mem[wr_ptr]      <= wr_data;
            last_mem[wr_ptr] <= wr_last;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end else begin
            if (wr_valid) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)    rd_ptr <= rd_ptr + 1'b1;
            case ({wr_valid, rd_en})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1;
                default: used <= used;             // idle or write+read together
            endcase
        end
    end

    // admission in the packer must keep writes off a full FIFO
    no_write_when_full: assert property (
        @(posedge adc_data_clk) disable iff (!acq_on)
        wr_valid |-> !full
    );

    // a stalled head word stays put until the sink takes it
    hold_until_taken: assert property (
        @(posedge adc_data_clk) disable iff (!acq_on)
        (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata) && $stable(m_tlast))
    );

endmodule

// ==== rtl/adc_stream_producer.sv ====
//**********************************************************
// ADC stream producer, top level
// phase counter, sample packer and stream FIFO on one clock
//**********************************************************

`timescale 1ns/1ps

module adc_stream_producer (
    input  logic                                         adc_data_clk,
    input  logic                                         acq_on,      // low = reset
    input  acq_pkg::sample_t [acq_pkg::adc_channels-1:0] adc_data,
    input  logic                                         big_endian,
    input  logic                                         m_tready,
    output logic                                         m_tvalid,
    output stream_pkg::word_t                            m_tdata,
    output logic                                         m_tlast
);

    acq_pkg::phase_t   phase;       // cycle within the ADC period
    logic              wr_valid;
    stream_pkg::word_t wr_data;
    logic              wr_last;
    logic              room;        // FIFO can take a whole sample

    sample_phase_counter phase_cnt0 (
        .adc_data_clk (adc_data_clk),
        .acq_on       (acq_on),
        .phase        (phase)
    );

    sample_packer packer0 (
        .adc_data_clk (adc_data_clk),
        .acq_on       (acq_on),
        .phase        (phase),
        .adc_data     (adc_data),
        .big_endian   (big_endian),
        .room         (room),
        .wr_valid     (wr_valid),
        .wr_data      (wr_data),
        .wr_last      (wr_last)
    );

    stream_fifo fifo0 (
        .adc_data_clk (adc_data_clk),
        .acq_on       (acq_on),
        .wr_valid     (wr_valid),
        .wr_data      (wr_data),
        .wr_last      (wr_last),
        .m_tready     (m_tready),
        .room         (room),
        .m_tvalid     (m_tvalid),
        .m_tdata      (m_tdata),
        .m_tlast      (m_tlast)
    );

endmodule

// ==== bench/tb_adc_stream_producer.sv ====
//**********************************************************
// testbench for the ADC stream producer
// random samples from xorshift, stalling sink, reference model
//**********************************************************

`timescale 1ns/1ps

module tb_adc_stream_producer;

    // about 150 periods are run, stalls and drains stretch some of them
    localparam int test_periods = 300;
    localparam int cycle_limit  = test_periods * acq_pkg::phase_len + 8000;

    logic                                         adc_data_clk = 1'b0;
    logic                                         acq_on;
    acq_pkg::sample_t [acq_pkg::adc_channels-1:0] adc_data;
    logic                                         big_endian;
    logic                                         m_tready;
    logic                                         m_tvalid;
    logic [127:0]                                 m_tdata;
    logic                                         m_tlast;

    logic [31:0]  rng_state;
    int           cycles;
    int           tb_phase;          // follows dut phase, 0 at reset release
    int           ready_mode;        // 0 high, 1 random, 2 stalled
    logic         swap_random;       // big_endian drawn per period
    logic [143:0] chan_hist [$];     // index = sample count of the period
    logic         endian_hist [$];
    logic         expect_w1;         // next transfer is word 1
    logic         strict_order;      // no drops allowed
    logic         saw_gap;
    int           last_count;        // count of the last whole sample
    int           pend_cnt;
    int           delivered;         // whole samples since reset
    int           swapped_seen;
    int           cnt_plain;
    int           cnt_swap;
    int           cnt;
    logic [127:0] unswapped;

    adc_stream_producer dut0 (
        .adc_data_clk (adc_data_clk),
        .acq_on       (acq_on),
        .adc_data     (adc_data),
        .big_endian   (big_endian),
        .m_tready     (m_tready),
        .m_tvalid     (m_tvalid),
        .m_tdata      (m_tdata),
        .m_tlast      (m_tlast)
    );

    always #2 adc_data_clk = ~adc_data_clk;   // 4 ns period

    //**********************************************************
    // helpers
    //**********************************************************
    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Regression failed");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // count bytes 0..3 sit in the low byte of each lane
    function automatic int count_bytes(input logic [127:0] d);
        return {d[103:96], d[71:64], d[39:32], d[7:0]};
    endfunction

    // lane j = {channel, 2 zero bits, channel index, count byte}, then optional reversal
    function automatic logic [127:0] expect_word(input logic [143:0] chans, input int count,
                                                 input int w, input logic swap);
        logic [127:0] d;
        logic [127:0] r;
        logic [63:0]  c;
        int           ch;
        c = 64'(count);
        for (int j = 0; j < 4; j++) begin
            ch = 4 * w + j;
            d[32*j +: 32] = {chans[18*ch +: 18], 2'b00, 4'(ch), c[8*ch +: 8]};
        end
        r = {<<8{d}};                          // all 16 bytes reversed
        return swap ? r : d;
    endfunction

    task automatic next_cycle();
        @(posedge adc_data_clk);
        #1;                                    // drive point after the edge
        cycles++;
        if (cycles > cycle_limit)
            fail_run($sformatf("timeout: the tests did not end within %0d cycles", cycle_limit));
    endtask

    // new channels and byte order, held for the whole period
    task automatic start_period();
        logic [31:0] r;
        for (int i = 0; i < acq_pkg::adc_channels; i++) begin
            r = next_random();
            adc_data[i] = r[17:0];
        end
        r = next_random();
        big_endian = swap_random && r[0];
        chan_hist.push_back(adc_data);
        endian_hist.push_back(big_endian);
    endtask

    task automatic step();
        logic [31:0] r;
        next_cycle();
        tb_phase = (tb_phase + 1) % acq_pkg::phase_len;
        if (tb_phase == 0) start_period();
        r = next_random();
        case (ready_mode)
            0:       m_tready = 1'b1;
            1:       m_tready = (r[1:0] != 2'b00);   // low one cycle in four
            default: m_tready = 1'b0;
        endcase
    endtask

    task automatic run_periods(input int n);
        repeat (n * acq_pkg::phase_len) step();
    endtask

    // until the sample of the running period has come out
    task automatic wait_current_sample();
        int target;
        target = chan_hist.size() - 1;
        while (last_count < target) step();
    endtask

    task automatic apply_reset();
        acq_on = 1'b0;
        chan_hist.delete();
        endian_hist.delete();
        expect_w1  = 1'b0;
        last_count = -1;
        delivered  = 0;
        repeat (3) begin
            next_cycle();
            assert (!m_tvalid)
                else fail_run($sformatf("[ERROR] time %0t: m_tvalid high in reset", $time));
        end
        acq_on   = 1'b1;
        tb_phase = 0;
        start_period();                        // period 0 has count 0
    endtask

    //**********************************************************
    // sink side model, sampled mid cycle
    //**********************************************************
    always @(negedge adc_data_clk) begin
        if (acq_on && m_tvalid && m_tready) begin
            if (!expect_w1) begin
                unswapped = {<<8{m_tdata}};
                cnt_plain = count_bytes(m_tdata);
                cnt_swap  = count_bytes(unswapped);
                if (cnt_plain > last_count && cnt_plain < chan_hist.size()
                    && !endian_hist[cnt_plain])
                    cnt = cnt_plain;
                else if (cnt_swap > last_count && cnt_swap < chan_hist.size()
                         && endian_hist[cnt_swap])
                    cnt = cnt_swap;
                else
                    cnt = -1;
                assert (cnt >= 0) else fail_run($sformatf(
                    "[ERROR] time %0t: word 0 %h matches no pending sample", $time, m_tdata));
                assert (!strict_order || cnt == last_count + 1) else fail_run($sformatf(
                    "[ERROR] time %0t: count %0d, expected %0d", $time, cnt, last_count + 1));
                assert (m_tdata == expect_word(chan_hist[cnt], cnt, 0, endian_hist[cnt]))
                    else fail_run($sformatf("[ERROR] time %0t: word 0 of sample %0d is %h",
                                            $time, cnt, m_tdata));
                assert (!m_tlast)
                    else fail_run($sformatf("[ERROR] time %0t: m_tlast on word 0", $time));
                if (cnt != last_count + 1) saw_gap = 1'b1;   // whole sample dropped
                if (endian_hist[cnt]) swapped_seen++;
                pend_cnt  = cnt;
                expect_w1 = 1'b1;
            end else begin
                assert (m_tdata == expect_word(chan_hist[pend_cnt], pend_cnt, 1,
                                               endian_hist[pend_cnt]))
                    else fail_run($sformatf("[ERROR] time %0t: word 1 of sample %0d is %h",
                                            $time, pend_cnt, m_tdata));
                assert (m_tlast == (delivered % stream_pkg::pkt_samples
                                    == stream_pkg::pkt_samples - 1))
                    else fail_run($sformatf("[ERROR] time %0t: m_tlast %b on sample %0d",
                                            $time, m_tlast, delivered));
                delivered++;
                last_count = pend_cnt;
                expect_w1  = 1'b0;
            end
        end
    end

    //**********************************************************
    // test sequence
    //**********************************************************
    initial begin
        rng_state    = 32'd59;
        acq_on       = 1'b0;
        adc_data     = '0;
        big_endian   = 1'b0;
        m_tready     = 1'b0;
        cycles       = 0;
        ready_mode   = 0;
        swap_random  = 1'b0;
        strict_order = 1'b1;
        saw_gap      = 1'b0;
        swapped_seen = 0;
        apply_reset();

        run_periods(36);                       // sink ready, two full packets
        wait_current_sample();
        assert (delivered >= 2 * stream_pkg::pkt_samples)
            else fail_run($sformatf("[ERROR] time %0t: only %0d samples", $time, delivered));

        swap_random = 1'b1;                    // mixed byte order
        run_periods(20);
        wait_current_sample();
        assert (swapped_seen > 0) else fail_run("no byte swapped sample was delivered");
        swap_random = 1'b0;

        strict_order = 1'b0;                   // long stalls fill the FIFO
        ready_mode = 1;
        run_periods(8);
        ready_mode = 2;
        run_periods(20);
        ready_mode = 1;
        run_periods(6);
        ready_mode = 2;
        run_periods(18);
        ready_mode = 1;
        run_periods(6);
        ready_mode = 0;
        run_periods(3);
        wait_current_sample();                 // delivery resumed
        assert (saw_gap) else fail_run("the stalls caused no dropped sample");

        strict_order = 1'b1;                   // reset in mid period
        ready_mode = 2;                        // sink stalled, FIFO holds words at reset
        run_periods(5);
        repeat (17) step();
        assert (m_tvalid) else fail_run("the FIFO was empty before the second reset");
        apply_reset();
        ready_mode = 0;
        run_periods(20);
        wait_current_sample();
        assert (delivered >= 20)
            else fail_run($sformatf("[ERROR] time %0t: only %0d samples", $time, delivered));

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== compile.f ====
rtl/acq_pkg.sv
rtl/stream_pkg.sv
rtl/sample_phase_counter.sv
rtl/sample_packer.sv
rtl/stream_fifo.sv
rtl/adc_stream_producer.sv
bench/tb_adc_stream_producer.sv

// ==== Makefile ====
SIM      = verilator
VFLAGS   = --binary --timing --assert
TOP      = tb_adc_stream_producer
FILELIST = compile.f
OBJ_DIR  = obj_dir

SRCS = $(shell cat $(FILELIST))
BIN  = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
